/* source/rename_params.svh */
// sizes and opcodes of the rename subsystem, included by the package and each rtl block
`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

// architectural register file, x0 is never renamed
`define ARCH_REGS 32
`define AREG_W 5

// physical register file
`define PHYS_REGS 64
`define PREG_W 6

// reorder buffer depth, a power of two so indices wrap
`define ROB_SZ 16
`define ROB_IDX_W 4

// rv32 major opcode for register-register alu ops
`define OPCODE_OP 7'b0110011

`endif

/* source/rename_pkg.sv */
// shared types of the rename subsystem, imported by every block that needs them
`default_nettype none

`include "rename_params.svh"

package rename_pkg;

    // register index types
    typedef logic [`AREG_W-1:0] areg_t;
    typedef logic [`PREG_W-1:0] preg_t;

    // register-register layout
    typedef struct packed {
        logic [6:0] funct7;
        areg_t      rs2;
        areg_t      rs1;
        logic [2:0] funct3;
        areg_t      rd;
        logic [6:0] opcode;
    } r_fmt_t;

    // immediate layout, imm replaces funct7 and rs2
    typedef struct packed {
        logic [11:0] imm;
        areg_t       rs1;
        logic [2:0]  funct3;
        areg_t       rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // one 32 bit word, decoded by opcode
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } inst_word_t;

    // packet handed out per dispatched instruction
    typedef struct packed {
        preg_t                 prs1;
        preg_t                 prs2;
        logic                  uses_rs2;
        logic                  has_rd;
        preg_t                 prd;
        preg_t                 prd_old;
        logic [`ROB_IDX_W-1:0] rob_idx;
    } rename_pkt_t;

    // what retire and walk-back need per entry
    typedef struct packed {
        logic  has_rd;
        areg_t rd;
        preg_t t;
        preg_t t_old;
    } rob_entry_t;

endpackage

`default_nettype wire

/* source/free_list.sv */
// ring of free physical register tags, popped at rename and refilled at retire or squash
`timescale 1ns/1ns
`default_nettype none

`include "rename_params.svh"

module free_list
    import rename_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    input  logic  alloc,
    output preg_t alloc_preg,
    output logic  empty,
    input  logic  release_en,
    input  preg_t release_preg
);

    // only the non-identity registers ever circulate
    localparam int FL_SZ    = `PHYS_REGS - `ARCH_REGS;
    localparam int FL_PTR_W = $clog2(FL_SZ);

    preg_t               ring [FL_SZ];
    logic [FL_PTR_W-1:0] head;
    logic [FL_PTR_W-1:0] tail;
    logic [FL_PTR_W:0]   count;
    logic                pop;

    // head entry is always presented, valid when not empty
    assign alloc_preg = ring[head];
    assign empty      = count == '0;

    // never pop past empty
    assign pop = alloc && !empty;

    always_ff @(posedge clock) begin
        if (reset) begin
            // tags 32..63 in order, list starts full
            for (int i = 0; i < FL_SZ; i++) begin
                ring[i] <= preg_t'(`ARCH_REGS + i);
            end
            head  <= '0;
            tail  <= '0;
            count <= (FL_PTR_W + 1)'(FL_SZ);
        end else begin
            if (pop) begin
                head <= (head == FL_PTR_W'(FL_SZ - 1)) ? '0 : head + 1'b1;
            end
            // push at tail
            if (release_en) begin
                ring[tail] <= release_preg;
                tail       <= (tail == FL_PTR_W'(FL_SZ - 1)) ? '0 : tail + 1'b1;
            end
            // pop and push together leave count alone
            case ({pop, release_en})
                2'b10:   count <= count - 1'b1;
                2'b01:   count <= count + 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/map_table.sv */
// speculative architectural to physical map, read at rename and rolled back by walk restore
`timescale 1ns/1ns
`default_nettype none

`include "rename_params.svh"

module map_table
    import rename_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    input  areg_t rs1,
    input  areg_t rs2,
    input  areg_t rd,
    output preg_t prs1,
    output preg_t prs2,
    output preg_t prd_old,
    input  logic  write_en,
    input  areg_t write_rd,
    input  preg_t write_preg,
    input  logic  restore_en,
    input  areg_t restore_rd,
    input  preg_t restore_preg
);

    preg_t map [`ARCH_REGS];

    // x0 pinned to p0
    assign prs1    = (rs1 == '0) ? '0 : map[rs1];
    assign prs2    = (rs2 == '0) ? '0 : map[rs2];
    assign prd_old = (rd == '0) ? '0 : map[rd];

    always_ff @(posedge clock) begin
        if (reset) begin
            // identity, xN lives in pN
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map[i] <= preg_t'(i);
            end
        end else if (restore_en) begin
            // walk-back wins, dispatch is stalled then anyway
            map[restore_rd] <= restore_preg;
        end else if (write_en) begin
            map[write_rd] <= write_preg;
        end
    end

endmodule

`default_nettype wire

/* source/rename_stage.sv */
// combinational dispatch stage, decodes the word and builds the rename packet and rob entry
`timescale 1ns/1ns
`default_nettype none

`include "rename_params.svh"

module rename_stage
    import rename_pkg::*;
(
    input  logic                  inst_valid,
    input  inst_word_t            inst_word,
    output logic                  inst_ready,
    input  logic                  rob_full,
    input  logic                  fl_empty,
    input  logic                  recovering,
    input  preg_t                 prs1,
    input  preg_t                 prs2,
    input  preg_t                 prd_old,
    input  preg_t                 alloc_preg,
    input  logic [`ROB_IDX_W-1:0] rob_tail,
    output areg_t                 lookup_rs1,
    output areg_t                 lookup_rs2,
    output areg_t                 lookup_rd,
    output logic                  alloc,
    output logic                  dispatch,
    output rob_entry_t            dispatch_entry,
    output logic                  rename_valid,
    output rename_pkt_t           rename_pkt
);

    logic uses_rs2;
    logic has_rd;

    // pick the view by opcode
    always_comb begin
        if (inst_word.r_fmt.opcode == `OPCODE_OP) begin
            uses_rs2   = 1'b1;
            lookup_rs1 = inst_word.r_fmt.rs1;
            lookup_rs2 = inst_word.r_fmt.rs2;
            lookup_rd  = inst_word.r_fmt.rd;
        end else begin
            // rs2 bits are immediate here
            uses_rs2   = 1'b0;
            lookup_rs1 = inst_word.i_fmt.rs1;
            lookup_rs2 = '0;
            lookup_rd  = inst_word.i_fmt.rd;
        end
    end

    assign has_rd = lookup_rd != '0;

    // stall rules
    assign inst_ready = !rob_full && !(fl_empty && has_rd) && !recovering;

    assign dispatch     = inst_valid && inst_ready;
    assign alloc        = dispatch && has_rd;
    assign rename_valid = dispatch;

    // no destination means no tags
    assign rename_pkt.prs1     = prs1;
    assign rename_pkt.prs2     = uses_rs2 ? prs2 : '0;
    assign rename_pkt.uses_rs2 = uses_rs2;
    assign rename_pkt.has_rd   = has_rd;
    assign rename_pkt.prd      = has_rd ? alloc_preg : '0;
    assign rename_pkt.prd_old  = has_rd ? prd_old : '0;
    assign rename_pkt.rob_idx  = rob_tail;

    assign dispatch_entry.has_rd = has_rd;
    assign dispatch_entry.rd     = lookup_rd;
    assign dispatch_entry.t      = rename_pkt.prd;
    assign dispatch_entry.t_old  = rename_pkt.prd_old;

endmodule

`default_nettype wire

/* source/reorder_buffer.sv */
// in-order instruction queue, frees old tags at retire and walks back from the tail on undo
`timescale 1ns/1ns
`default_nettype none

`include "rename_params.svh"

module reorder_buffer
    import rename_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  dispatch,
    input  rob_entry_t            dispatch_entry,
    output logic [`ROB_IDX_W-1:0] tail_idx,
    output logic                  full,
    input  logic                  retire,
    output logic                  head_valid,
    output areg_t                 head_rd,
    output preg_t                 head_t,
    input  logic                  undo,
    input  logic [`ROB_IDX_W-1:0] undo_index,
    output logic                  recovering,
    output logic                  release_en,
    output preg_t                 release_preg,
    output logic                  restore_en,
    output areg_t                 restore_rd,
    output preg_t                 restore_preg
);

    rob_entry_t            entries [`ROB_SZ];
    logic [`ROB_IDX_W-1:0] head;
    logic [`ROB_IDX_W-1:0] tail;
    // extra bit so full and empty differ
    logic [`ROB_IDX_W:0]   count;
    logic [`ROB_IDX_W-1:0] stop_idx;
    logic [`ROB_IDX_W-1:0] walk_idx;
    logic [`ROB_IDX_W-1:0] tail_next;
    logic [`ROB_IDX_W-1:0] undo_stop;
    logic                  retire_take;
    rob_entry_t            head_entry;
    rob_entry_t            walk_entry;

    assign tail_idx   = tail;
    assign full       = count == (`ROB_IDX_W + 1)'(`ROB_SZ);
    assign head_valid = count != '0;

    assign head_entry = entries[head];
    assign head_rd    = head_entry.rd;
    assign head_t     = head_entry.t;

    // retire ignored while squashing
    assign retire_take = retire && head_valid && !recovering;

    // youngest live entry, squashed this cycle when recovering
    assign walk_idx   = tail - 1'b1;
    assign walk_entry = entries[walk_idx];

    // tail after a dispatch in the undo cycle
    assign tail_next = dispatch ? tail + 1'b1 : tail;
    // first entry younger than the branch
    assign undo_stop = undo_index + 1'b1;

    // walk puts back the previous mapping
    assign restore_en   = recovering && walk_entry.has_rd;
    assign restore_rd   = walk_entry.rd;
    assign restore_preg = walk_entry.t_old;

    // one free-list return per cycle
    always_comb begin
        if (recovering) begin
            // squashed new tag
            release_en   = walk_entry.has_rd;
            release_preg = walk_entry.t;
        end else begin
            // retired old tag
            release_en   = retire_take && head_entry.has_rd;
            release_preg = head_entry.t_old;
        end
    end

    // payload storage
    always_ff @(posedge clock) begin
        if (dispatch) begin
            entries[tail] <= dispatch_entry;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head       <= '0;
            tail       <= '0;
            count      <= '0;
            stop_idx   <= '0;
            recovering <= 1'b0;
        end else begin
            if (retire_take) begin
                head <= head + 1'b1;
            end
            if (recovering) begin
                // one entry per cycle
                tail <= walk_idx;
                if (walk_idx == stop_idx) begin
                    recovering <= 1'b0;
                end
            end else begin
                tail <= tail_next;
                // nothing younger means no walk
                if (undo) begin
                    stop_idx   <= undo_stop;
                    recovering <= undo_stop != tail_next;
                end
            end
            // dispatch never meets a walk step
            case ({dispatch, retire_take || recovering})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/rename_top.sv */
// rename and reorder subsystem top, wires free list, map table, dispatch stage and rob together
`timescale 1ns/1ns
`default_nettype none

`include "rename_params.svh"

module rename_top
    import rename_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  inst_valid,
    input  inst_word_t            inst_word,
    output logic                  inst_ready,
    output logic                  rename_valid,
    output rename_pkt_t           rename_pkt,
    input  logic                  retire,
    output logic                  head_valid,
    output areg_t                 head_rd,
    output preg_t                 head_t,
    output preg_t                 retired_t_old,
    input  logic                  undo,
    input  logic [`ROB_IDX_W-1:0] undo_index,
    output logic                  recovering
);

    // free list handshake
    logic  alloc;
    logic  fl_empty;
    preg_t alloc_preg;
    logic  release_en;
    preg_t release_preg;

    // map lookups and rollback
    areg_t lookup_rs1;
    areg_t lookup_rs2;
    areg_t lookup_rd;
    preg_t prs1;
    preg_t prs2;
    preg_t prd_old;
    logic  restore_en;
    areg_t restore_rd;
    preg_t restore_preg;

    // rob side
    logic                  dispatch;
    rob_entry_t            dispatch_entry;
    logic                  rob_full;
    logic [`ROB_IDX_W-1:0] rob_tail;

    // rob return port carries t_old on retire
    assign retired_t_old = release_preg;

    free_list u_free_list (
        .clock        (clock),
        .reset        (reset),
        .alloc        (alloc),
        .alloc_preg   (alloc_preg),
        .empty        (fl_empty),
        .release_en   (release_en),
        .release_preg (release_preg)
    );

    // map write is the allocation itself
    map_table u_map_table (
        .clock        (clock),
        .reset        (reset),
        .rs1          (lookup_rs1),
        .rs2          (lookup_rs2),
        .rd           (lookup_rd),
        .prs1         (prs1),
        .prs2         (prs2),
        .prd_old      (prd_old),
        .write_en     (alloc),
        .write_rd     (lookup_rd),
        .write_preg   (alloc_preg),
        .restore_en   (restore_en),
        .restore_rd   (restore_rd),
        .restore_preg (restore_preg)
    );

    rename_stage u_rename_stage (
        .inst_valid     (inst_valid),
        .inst_word      (inst_word),
        .inst_ready     (inst_ready),
        .rob_full       (rob_full),
        .fl_empty       (fl_empty),
        .recovering     (recovering),
        .prs1           (prs1),
        .prs2           (prs2),
        .prd_old        (prd_old),
        .alloc_preg     (alloc_preg),
        .rob_tail       (rob_tail),
        .lookup_rs1     (lookup_rs1),
        .lookup_rs2     (lookup_rs2),
        .lookup_rd      (lookup_rd),
        .alloc          (alloc),
        .dispatch       (dispatch),
        .dispatch_entry (dispatch_entry),
        .rename_valid   (rename_valid),
        .rename_pkt     (rename_pkt)
    );

    reorder_buffer u_reorder_buffer (
        .clock          (clock),
        .reset          (reset),
        .dispatch       (dispatch),
        .dispatch_entry (dispatch_entry),
        .tail_idx       (rob_tail),
        .full           (rob_full),
        .retire         (retire),
        .head_valid     (head_valid),
        .head_rd        (head_rd),
        .head_t         (head_t),
        .undo           (undo),
        .undo_index     (undo_index),
        .recovering     (recovering),
        .release_en     (release_en),
        .release_preg   (release_preg),
        .restore_en     (restore_en),
        .restore_rd     (restore_rd),
        .restore_preg   (restore_preg)
    );

endmodule

`default_nettype wire

/* dv/rename_tb.sv */
// directed testbench for rename_top, checks dispatch, retire and undo walk against a reference model
`timescale 1ns/1ns
`default_nettype none

`include "rename_params.svh"

module rename_tb
    import rename_pkg::*;
();

    localparam logic [6:0] OP_OPCODE  = 7'b0110011;
    localparam logic [6:0] IMM_OPCODE = 7'b0010011;
    // all six tests together take roughly two hundred fifty cycles
    localparam int MAX_CYCLES = 2000;

    logic                  clock;
    logic                  reset;
    logic                  inst_valid;
    inst_word_t            inst_word;
    logic                  inst_ready;
    logic                  rename_valid;
    rename_pkt_t           rename_pkt;
    logic                  retire;
    logic                  head_valid;
    areg_t                 head_rd;
    preg_t                 head_t;
    preg_t                 retired_t_old;
    logic                  undo;
    logic [`ROB_IDX_W-1:0] undo_index;
    logic                  recovering;

    // reference model, free tags in order, speculative map, live rob entries
    preg_t                 free_q [$];
    preg_t                 map_m [`ARCH_REGS];
    preg_t                 snap_m [`ARCH_REGS];
    rob_entry_t            rob_q [$];
    logic [`ROB_IDX_W-1:0] tail_m;

    int          cycles;
    int          errors;
    int          err_mark;
    int          tests_run;
    int          tests_failed;
    int unsigned seed;

    rename_top uut (
        .clock         (clock),
        .reset         (reset),
        .inst_valid    (inst_valid),
        .inst_word     (inst_word),
        .inst_ready    (inst_ready),
        .rename_valid  (rename_valid),
        .rename_pkt    (rename_pkt),
        .retire        (retire),
        .head_valid    (head_valid),
        .head_rd       (head_rd),
        .head_t        (head_t),
        .retired_t_old (retired_t_old),
        .undo          (undo),
        .undo_index    (undo_index),
        .recovering    (recovering)
    );

    // 4 ns period
    always #2 clock = ~clock;

    // run limit
    always @(posedge clock) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic check_value(input string what, input int got, input int exp);
        assert (got == exp) else begin
            $display("Fail at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == err_mark) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d checks failed", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // state right after reset
    task automatic reset_model();
        free_q.delete();
        rob_q.delete();
        for (int i = `ARCH_REGS; i < `PHYS_REGS; i++) begin
            free_q.push_back(preg_t'(i));
        end
        for (int i = 0; i < `ARCH_REGS; i++) begin
            map_m[i] = preg_t'(i);
        end
        tail_m = '0;
    endtask

    function automatic areg_t random_reg();
        return areg_t'($urandom_range(31, 1));
    endfunction

    // one instruction through the handshake, packet checked in the dispatch cycle
    task automatic send_inst(input bit is_op, input areg_t rs1, input areg_t rs2,
                             input areg_t rd);
        inst_word_t word;
        rob_entry_t ent;
        // funct and immediate bits stay random
        word = $urandom;
        word.r_fmt.rs1 = rs1;
        word.r_fmt.rd  = rd;
        if (is_op) begin
            word.r_fmt.opcode = OP_OPCODE;
            word.r_fmt.rs2    = rs2;
        end else begin
            word.i_fmt.opcode = IMM_OPCODE;
        end
        ent.has_rd = rd != '0;
        ent.rd     = rd;
        ent.t      = ent.has_rd ? free_q[0] : '0;
        ent.t_old  = ent.has_rd ? map_m[rd] : '0;
        inst_word  = word;
        inst_valid = 1'b1;
        #1;
        while (!inst_ready) begin
            @(negedge clock);
            #1;
        end
        check_value("rename_valid", rename_valid, 1);
        check_value("prs1", rename_pkt.prs1, map_m[rs1]);
        check_value("prs2", rename_pkt.prs2, is_op ? map_m[rs2] : 0);
        check_value("uses_rs2", rename_pkt.uses_rs2, is_op);
        check_value("has_rd", rename_pkt.has_rd, ent.has_rd);
        check_value("prd", rename_pkt.prd, ent.t);
        check_value("prd_old", rename_pkt.prd_old, ent.t_old);
        check_value("rob_idx", rename_pkt.rob_idx, tail_m);
        @(posedge clock);
        @(negedge clock);
        inst_valid = 1'b0;
        if (ent.has_rd) begin
            void'(free_q.pop_front());
            map_m[rd] = ent.t;
        end
        rob_q.push_back(ent);
        tail_m++;
    endtask

    task automatic send_random_op();
        send_inst(1'b1, random_reg(), random_reg(), random_reg());
    endtask

    // oldest entry leaves, its old tag joins the back of the free list
    task automatic retire_one();
        rob_entry_t ent;
        ent    = rob_q[0];
        retire = 1'b1;
        #1;
        check_value("head_valid", head_valid, 1);
        check_value("head_rd", head_rd, ent.rd);
        check_value("head_t", head_t, ent.t);
        check_value("retired_t_old", retired_t_old, ent.t_old);
        @(posedge clock);
        @(negedge clock);
        retire = 1'b0;
        void'(rob_q.pop_front());
        if (ent.has_rd) begin
            free_q.push_back(ent.t_old);
        end
    endtask

    // dispatch and retire in turn, cycles tags through the whole free list
    task automatic churn(input int n);
        repeat (n) begin
            send_random_op();
            retire_one();
        end
    endtask

    // undo at model entry k, counts walk cycles, optionally holds retire meanwhile
    task automatic do_undo(input int k, input bit hold_retire);
        int         younger;
        int         walked;
        areg_t      h_rd;
        preg_t      h_t;
        rob_entry_t ent;
        younger    = rob_q.size() - 1 - k;
        walked     = 0;
        // oldest live entry must stay at the head
        h_rd       = rob_q[0].rd;
        h_t        = rob_q[0].t;
        undo       = 1'b1;
        undo_index = tail_m - `ROB_IDX_W'(rob_q.size() - k);
        @(posedge clock);
        @(negedge clock);
        undo   = 1'b0;
        retire = hold_retire;
        while (recovering) begin
            walked++;
            if (hold_retire) begin
                check_value("head_valid in walk", head_valid, 1);
                check_value("head_rd in walk", head_rd, h_rd);
                check_value("head_t in walk", head_t, h_t);
            end
            @(negedge clock);
        end
        retire = 1'b0;
        check_value("walk cycles", walked, younger);
        // youngest first, map back to t_old, t to the free list
        repeat (younger) begin
            ent = rob_q.pop_back();
            if (ent.has_rd) begin
                map_m[ent.rd] = ent.t_old;
                free_q.push_back(ent.t);
            end
            tail_m--;
        end
    endtask

    // reads every mapping through the lookup path, no dispatch
    task automatic probe_map();
        inst_word_t word;
        for (int r = 1; r < `ARCH_REGS; r++) begin
            word              = '0;
            word.r_fmt.opcode = OP_OPCODE;
            word.r_fmt.rs1    = areg_t'(r);
            word.r_fmt.rs2    = areg_t'(`ARCH_REGS - r);
            inst_word         = word;
            #1;
            check_value($sformatf("map of x%0d", r), rename_pkt.prs1, snap_m[r]);
            check_value($sformatf("map of x%0d", `ARCH_REGS - r), rename_pkt.prs2,
                        snap_m[`ARCH_REGS - r]);
            @(negedge clock);
        end
    endtask

    task automatic test_op_chain();
        // dependent chain first, tags from 32 upward
        send_inst(1'b1, 5'd1, 5'd2, 5'd3);
        send_inst(1'b1, 5'd3, 5'd3, 5'd4);
        send_inst(1'b1, 5'd4, 5'd3, 5'd3);
        repeat (3) begin
            send_random_op();
        end
        finish_test("op_chain");
    endtask

    task automatic test_imm_and_x0();
        send_inst(1'b0, random_reg(), random_reg(), random_reg());
        // rd zero takes no tag
        send_inst(1'b0, random_reg(), random_reg(), 5'd0);
        send_inst(1'b1, random_reg(), random_reg(), 5'd0);
        send_random_op();
        finish_test("imm_and_x0");
    endtask

    task automatic test_rob_full();
        inst_word_t word;
        while (rob_q.size() < `ROB_SZ) begin
            send_random_op();
        end
        word              = $urandom;
        word.r_fmt.opcode = OP_OPCODE;
        word.r_fmt.rd     = random_reg();
        inst_word         = word;
        inst_valid        = 1'b1;
        repeat (3) begin
            #1;
            check_value("inst_ready when full", inst_ready, 0);
            check_value("rename_valid when full", rename_valid, 0);
            @(negedge clock);
        end
        inst_valid = 1'b0;
        retire_one();
        #1;
        check_value("inst_ready after retire", inst_ready, 1);
        @(negedge clock);
        finish_test("rob_full");
    endtask

    task automatic test_retire_order();
        while (rob_q.size() > 0) begin
            retire_one();
        end
        check_value("head_valid when empty", head_valid, 0);
        // long enough to reach the retired tags
        churn(free_q.size() + 2);
        finish_test("retire_order");
    endtask

    task automatic test_undo_walk();
        int k;
        k = $urandom_range(5, 0);
        for (int i = 0; i < 8; i++) begin
            send_random_op();
            if (i == k) begin
                for (int r = 0; r < `ARCH_REGS; r++) begin
                    snap_m[r] = map_m[r];
                end
            end
        end
        do_undo(k, 1'b0);
        probe_map();
        while (rob_q.size() > 0) begin
            retire_one();
        end
        // squashed tags sit behind the older free ones
        churn(free_q.size() + 2);
        finish_test("undo_walk");
    endtask

    task automatic test_retire_in_walk();
        repeat (6) begin
            send_random_op();
        end
        do_undo(0, 1'b1);
        // branch is the youngest, nothing to walk
        do_undo(0, 1'b0);
        retire_one();
        check_value("head_valid at end", head_valid, 0);
        finish_test("retire_in_walk");
    endtask

    initial begin
        seed = 32'h2bc4ab87;
        void'($urandom(seed));
        clock        = 1'b0;
        reset        = 1'b1;
        inst_valid   = 1'b0;
        inst_word    = '0;
        retire       = 1'b0;
        undo         = 1'b0;
        undo_index   = '0;
        cycles       = 0;
        errors       = 0;
        err_mark     = 0;
        tests_run    = 0;
        tests_failed = 0;
        reset_model();
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        test_op_chain();
        test_imm_and_x0();
        test_rob_full();
        test_retire_order();
        test_undo_walk();
        test_retire_in_walk();

        $display("tests run %0d, passed %0d, failed %0d", tests_run,
                 tests_run - tests_failed, tests_failed);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+source
source/rename_pkg.sv
source/free_list.sv
source/map_table.sv
source/rename_stage.sv
source/reorder_buffer.sv
source/rename_top.sv
dv/rename_tb.sv
